//--- rtl/mem_config.svh
`ifndef MEM_CONFIG_SVH
`define MEM_CONFIG_SVH

// --------------------------------------------------
// memory geometry
// --------------------------------------------------

// word address width, 2^10 = 1K words
`define MEM_ADDR_BITS 10

// one RV32 word
`define MEM_DATA_WIDTH 32

// byte address = word address plus lane select
`define MEM_BYTE_ADDR_BITS (`MEM_ADDR_BITS + 2)

`endif

//--- rtl/mem_pkg.sv
package mem_pkg;

    // --------------------------------------------------
    // load/store opcodes
    // --------------------------------------------------
    typedef enum logic [2:0] {
        OP_LB  = 3'd0,  // load byte, sign extended
        OP_LH  = 3'd1,  // load halfword, sign extended
        OP_LW  = 3'd2,  // load word
        OP_LBU = 3'd3,  // load byte, zero extended
        OP_LHU = 3'd4,  // load halfword, zero extended
        OP_SB  = 3'd5,  // store byte, read-modify-write
        OP_SH  = 3'd6,  // store halfword, read-modify-write
        OP_SW  = 3'd7   // store word, direct write
    } mem_op_e;

    // --------------------------------------------------
    // access sequencer states
    // --------------------------------------------------
    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,  // waiting for start
        ST_READ  = 2'd1,  // rd strobe low
        ST_WRITE = 2'd2,  // wr strobe low
        ST_DONE  = 2'd3   // result cycle
    } seq_state_e;

endpackage

//--- rtl/memory.sv
`timescale 1ns/1ps
`include "mem_config.svh"

// 1024x32 dual strobe block RAM, acts on the falling edge
// so the rising-edge sequencer sees the result a half cycle later
module memory (
    input  logic                       clk_i,   // RAM samples on negedge
    input  logic [`MEM_DATA_WIDTH-1:0] data_i,  // write data
    input  logic [`MEM_ADDR_BITS-1:0]  addr_i,  // word address
    input  logic                       wr_i,    // write strobe, active low
    input  logic                       rd_i,    // read strobe, active low
    output logic [`MEM_DATA_WIDTH-1:0] data_o   // read data, held until next read
);

    // --------------------------------------------------
    // storage
    // --------------------------------------------------
    logic [`MEM_DATA_WIDTH-1:0] mem [0:(1<<`MEM_ADDR_BITS)-1];

    // --------------------------------------------------
    // write port
    // --------------------------------------------------
    always_ff @(negedge clk_i) begin
        if (!wr_i) begin
            mem[addr_i] <= data_i;  // whole word, no byte enables
        end
    end

    // --------------------------------------------------
    // read port
    // --------------------------------------------------
    // registered output, only updates on a read strobe
    always_ff @(negedge clk_i) begin
        if (!rd_i) begin
            data_o <= mem[addr_i];
        end
    end

endmodule

//--- rtl/load_align.sv
`timescale 1ns/1ps
`include "mem_config.svh"

// picks the addressed lane out of the read word and extends it
// little endian: byte 0 sits in bits 7:0
module load_align (
    input  mem_pkg::mem_op_e           op_i,      // latched opcode
    input  logic [1:0]                 offset_i,  // byte offset in the word
    input  logic [`MEM_DATA_WIDTH-1:0] word_i,    // word from the RAM
    output logic [`MEM_DATA_WIDTH-1:0] data_o     // extended load result
);

    logic [7:0]  byte_lane;  // selected byte
    logic [15:0] half_lane;  // selected halfword

    // --------------------------------------------------
    // lane select
    // --------------------------------------------------
    always_comb begin
        // offset * 8 gives the byte lane base bit
        byte_lane = word_i[{offset_i, 3'b000} +: 8];
        // halfword lane only depends on offset bit 1
        half_lane = word_i[{offset_i[1], 4'b0000} +: 16];
    end

    // --------------------------------------------------
    // extension
    // --------------------------------------------------
    always_comb begin
        case (op_i)
            mem_pkg::OP_LB: begin
                data_o = {{(`MEM_DATA_WIDTH-8){byte_lane[7]}}, byte_lane};  // sign
            end
            mem_pkg::OP_LBU: begin
                data_o = {{(`MEM_DATA_WIDTH-8){1'b0}}, byte_lane};  // zero
            end
            mem_pkg::OP_LH: begin
                data_o = {{(`MEM_DATA_WIDTH-16){half_lane[15]}}, half_lane};
            end
            mem_pkg::OP_LHU: begin
                data_o = {{(`MEM_DATA_WIDTH-16){1'b0}}, half_lane};
            end
            mem_pkg::OP_LW: begin
                data_o = word_i;
            end
            default: begin
                // stores, result unused
                data_o = word_i;
            end
        endcase
    end

endmodule

//--- rtl/store_merge.sv
`timescale 1ns/1ps
`include "mem_config.svh"

// builds the word written back to the RAM
// sub-word stores patch the old word read just before
module store_merge (
    input  mem_pkg::mem_op_e           op_i,      // latched opcode
    input  logic [1:0]                 offset_i,  // byte offset in the word
    input  logic [`MEM_DATA_WIDTH-1:0] old_i,     // word read from the RAM
    input  logic [`MEM_DATA_WIDTH-1:0] data_i,    // store data, low lanes used
    output logic [`MEM_DATA_WIDTH-1:0] word_o     // word to write
);

    // --------------------------------------------------
    // lane merge
    // --------------------------------------------------
    always_comb begin
        word_o = old_i;  // untouched lanes keep old value
        case (op_i)
            mem_pkg::OP_SB: begin
                // low byte of data into the addressed byte
                word_o[{offset_i, 3'b000} +: 8] = data_i[7:0];
            end
            mem_pkg::OP_SH: begin
                // low half into lane 0 or 1
                word_o[{offset_i[1], 4'b0000} +: 16] = data_i[15:0];
            end
            mem_pkg::OP_SW: begin
                word_o = data_i;  // full word, old value ignored
            end
            default: begin
                // loads never write
                word_o = old_i;
            end
        endcase
    end

endmodule

//--- rtl/mem_sequencer.sv
`timescale 1ns/1ps
`include "mem_config.svh"

// access FSM: latches a request, checks alignment,
// then orders the RAM read and write strobes
module mem_sequencer (
    input  logic                          clk_i,
    input  logic                          reset_i,     // sync, active high
    input  logic                          start_i,     // one-cycle request strobe
    input  mem_pkg::mem_op_e              op_i,
    input  logic [`MEM_BYTE_ADDR_BITS-1:0] addr_i,     // byte address
    input  logic [`MEM_DATA_WIDTH-1:0]    wdata_i,
    output mem_pkg::mem_op_e              op_o,        // latched opcode
    output logic [1:0]                    offset_o,    // latched byte offset
    output logic [`MEM_DATA_WIDTH-1:0]    wdata_o,     // latched store data
    output logic [`MEM_ADDR_BITS-1:0]     mem_addr_o,  // word address to RAM
    output logic                          mem_rd_n_o,  // active low
    output logic                          mem_wr_n_o,  // active low
    output logic                          busy_o,
    output logic                          done_o,      // one-cycle pulse
    output logic                          err_o        // misaligned, valid with done
);

    mem_pkg::seq_state_e              state_q;
    mem_pkg::mem_op_e                 op_q;
    logic [`MEM_BYTE_ADDR_BITS-1:0]   addr_q;
    logic [`MEM_DATA_WIDTH-1:0]       wdata_q;
    logic                             err_q;     // misalignment seen at accept
    logic                             accept;    // start taken this edge
    logic                             misalign;  // request fails alignment

    // --------------------------------------------------
    // alignment check, only used at acceptance
    // --------------------------------------------------
    always_comb begin
        case (op_i)
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: misalign = addr_i[0];
            mem_pkg::OP_LW, mem_pkg::OP_SW: misalign = |addr_i[1:0];
            default: misalign = 1'b0;  // bytes are always aligned
        endcase
    end

    assign accept = start_i && (state_q == mem_pkg::ST_IDLE);  // ignored while busy

    // --------------------------------------------------
    // state register
    // --------------------------------------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_q <= mem_pkg::ST_IDLE;
            err_q   <= 1'b0;
        end else begin
            case (state_q)
                mem_pkg::ST_IDLE: begin
                    if (accept) begin
                        err_q <= misalign;
                        if (misalign) begin
                            state_q <= mem_pkg::ST_DONE;   // no RAM access
                        end else if (op_i == mem_pkg::OP_SW) begin
                            state_q <= mem_pkg::ST_WRITE;  // no read needed
                        end else begin
                            state_q <= mem_pkg::ST_READ;   // loads, SB, SH
                        end
                    end
                end
                mem_pkg::ST_READ: begin
                    // sub-word stores go on to write the merged word
                    if (op_q == mem_pkg::OP_SB || op_q == mem_pkg::OP_SH) begin
                        state_q <= mem_pkg::ST_WRITE;
                    end else begin
                        state_q <= mem_pkg::ST_DONE;
                    end
                end
                mem_pkg::ST_WRITE: state_q <= mem_pkg::ST_DONE;
                mem_pkg::ST_DONE:  state_q <= mem_pkg::ST_IDLE;
                default:           state_q <= mem_pkg::ST_IDLE;
            endcase
        end
    end

    // request payload, held for the whole access
    always_ff @(posedge clk_i) begin
        if (accept) begin
            op_q    <= op_i;
            addr_q  <= addr_i;
            wdata_q <= wdata_i;
        end
    end

    // --------------------------------------------------
    // outputs
    // --------------------------------------------------
    assign op_o       = op_q;
    assign offset_o   = addr_q[1:0];
    assign wdata_o    = wdata_q;
    assign mem_addr_o = addr_q[`MEM_BYTE_ADDR_BITS-1:2];  // drop lane bits
    assign mem_rd_n_o = (state_q != mem_pkg::ST_READ);    // low for the read cycle
    assign mem_wr_n_o = (state_q != mem_pkg::ST_WRITE);   // low for the write cycle
    assign busy_o     = (state_q != mem_pkg::ST_IDLE);
    assign done_o     = (state_q == mem_pkg::ST_DONE);
    assign err_o      = done_o && err_q;

endmodule

//--- rtl/mem_unit.sv
`timescale 1ns/1ps
`include "mem_config.svh"

// data memory access unit, top level
module mem_unit (
    input  logic                           clk_i,
    input  logic                           reset_i,  // sync, active high
    input  logic                           start_i,  // request strobe
    input  mem_pkg::mem_op_e               op_i,
    input  logic [`MEM_BYTE_ADDR_BITS-1:0] addr_i,   // byte address
    input  logic [`MEM_DATA_WIDTH-1:0]     wdata_i,
    output logic [`MEM_DATA_WIDTH-1:0]     rdata_o,  // load result
    output logic                           busy_o,
    output logic                           done_o,
    output logic                           err_o
);

    mem_pkg::mem_op_e              seq_op;      // latched opcode
    logic [1:0]                    seq_offset;  // latched byte offset
    logic [`MEM_DATA_WIDTH-1:0]    seq_wdata;   // latched store data
    logic [`MEM_ADDR_BITS-1:0]     mem_addr;
    logic                          mem_rd_n;
    logic                          mem_wr_n;
    logic [`MEM_DATA_WIDTH-1:0]    mem_wdata;   // merged word
    logic [`MEM_DATA_WIDTH-1:0]    mem_rdata;   // RAM output, shared

    // --------------------------------------------------
    // control
    // --------------------------------------------------
    mem_sequencer u_seq (
        .clk_i      (clk_i),
        .reset_i    (reset_i),
        .start_i    (start_i),
        .op_i       (op_i),
        .addr_i     (addr_i),
        .wdata_i    (wdata_i),
        .op_o       (seq_op),
        .offset_o   (seq_offset),
        .wdata_o    (seq_wdata),
        .mem_addr_o (mem_addr),
        .mem_rd_n_o (mem_rd_n),
        .mem_wr_n_o (mem_wr_n),
        .busy_o     (busy_o),
        .done_o     (done_o),
        .err_o      (err_o)
    );

    // --------------------------------------------------
    // RAM and datapath
    // --------------------------------------------------
    memory u_mem (
        .clk_i  (clk_i),
        .data_i (mem_wdata),
        .addr_i (mem_addr),
        .wr_i   (mem_wr_n),
        .rd_i   (mem_rd_n),
        .data_o (mem_rdata)
    );

    load_align u_load (
        .op_i     (seq_op),
        .offset_i (seq_offset),
        .word_i   (mem_rdata),
        .data_o   (rdata_o)    // straight out, valid with done
    );

    store_merge u_store (
        .op_i     (seq_op),
        .offset_i (seq_offset),
        .old_i    (mem_rdata),  // word from the read cycle
        .data_i   (seq_wdata),
        .word_o   (mem_wdata)
    );

endmodule

//--- testbench/tb_mem_unit.sv
`timescale 1ns/1ps
`include "mem_config.svh"

module tb_mem_unit;

    localparam int CLK_PERIOD = 20;
    // total request count over all test groups sizes the watchdog
    localparam int N_REQ = 2*1024 + 2*32 + 8*12 + 2*13 + 2*10 + 3;
    localparam int WATCHDOG_CYCLES = N_REQ * 5 + 50;
    localparam logic [11:0] VICTIM_ADDR = 12'h010;  // target of the ignored strobe

    logic clk;
    logic reset;
    logic start;
    mem_pkg::mem_op_e op;
    logic [`MEM_BYTE_ADDR_BITS-1:0] addr;
    logic [`MEM_DATA_WIDTH-1:0] wdata;
    logic [`MEM_DATA_WIDTH-1:0] rdata;
    logic busy;
    logic done;
    logic err;

    logic [31:0] model [0:1023];  // expected memory contents
    logic [31:0] seed = 32'd80;
    logic [31:0] exp_data_q [$];  // one entry per request in flight
    logic exp_err_q [$];
    logic is_load_q [$];
    logic [31:0] pop_data;
    logic pop_err;
    logic pop_load;
    logic [31:0] rnd;
    logic [31:0] val;
    logic [9:0] base;
    int error_count = 0;
    int request_count = 0;
    int i;
    int j;

    mem_unit dut (
        .clk_i   (clk),
        .reset_i (reset),
        .start_i (start),
        .op_i    (op),
        .addr_i  (addr),
        .wdata_i (wdata),
        .rdata_o (rdata),
        .busy_o  (busy),
        .done_o  (done),
        .err_o   (err)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    // --------------------------------------------------
    // helpers
    // --------------------------------------------------
    function automatic logic [31:0] next_random();
        seed = seed * 32'd1664525 + 32'd1013904223;  // 32-bit LCG
        return seed;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s got %h expected %h", name, got, exp);
            error_count++;
        end
    endtask

    // expected result of one request; stores update the model
    function automatic logic [31:0] reference_access(input mem_pkg::mem_op_e rop,
            input logic [11:0] raddr, input logic [31:0] rwdata, output logic rerr);
        logic [9:0]  idx;
        logic [4:0]  sh;
        logic [31:0] word;
        logic [31:0] mask;
        logic [31:0] result;
        idx    = raddr[11:2];
        sh     = {raddr[1:0], 3'b000};  // lane position in bits
        word   = model[idx];
        result = 32'h0;
        case (rop)
            mem_pkg::OP_LH, mem_pkg::OP_LHU, mem_pkg::OP_SH: rerr = raddr[0];
            mem_pkg::OP_LW, mem_pkg::OP_SW: rerr = (raddr[1:0] != 2'b00);
            default: rerr = 1'b0;
        endcase
        if (!rerr) begin
            case (rop)
                mem_pkg::OP_LB: begin
                    result = (word >> sh) & 32'hff;
                    if (result[7]) result = result | 32'hffff_ff00;
                end
                mem_pkg::OP_LBU: result = (word >> sh) & 32'hff;
                mem_pkg::OP_LH: begin
                    result = (word >> sh) & 32'hffff;
                    if (result[15]) result = result | 32'hffff_0000;
                end
                mem_pkg::OP_LHU: result = (word >> sh) & 32'hffff;
                mem_pkg::OP_LW: result = word;
                mem_pkg::OP_SB: begin
                    mask = 32'hff << sh;
                    model[idx] = (word & ~mask) | ((rwdata & 32'hff) << sh);
                end
                mem_pkg::OP_SH: begin
                    mask = 32'hffff << sh;
                    model[idx] = (word & ~mask) | ((rwdata & 32'hffff) << sh);
                end
                mem_pkg::OP_SW: model[idx] = rwdata;
                default: result = 32'h0;
            endcase
        end
        return result;
    endfunction

    // one request with done_o wait and latency check
    task automatic issue_request(input mem_pkg::mem_op_e rop, input logic [11:0] raddr,
                                 input logic [31:0] rwdata, input logic poke_busy);
        logic [31:0] e_data;
        logic e_err;
        int e_edges;
        int edges;
        logic got;
        e_data = reference_access(rop, raddr, rwdata, e_err);
        if (e_err) e_edges = 1;
        else if (rop == mem_pkg::OP_SB || rop == mem_pkg::OP_SH) e_edges = 3;  // rmw
        else e_edges = 2;
        exp_data_q.push_back(e_data);
        exp_err_q.push_back(e_err);
        is_load_q.push_back(rop != mem_pkg::OP_SB && rop != mem_pkg::OP_SH &&
                            rop != mem_pkg::OP_SW);
        @(posedge clk);
        start <= 1'b1;
        op    <= rop;
        addr  <= raddr;
        wdata <= rwdata;
        @(negedge clk);
        check_value("busy_o", {31'b0, busy}, 32'h0);  // idle before the accepting edge
        edges = 0;
        got   = 1'b0;
        while (!got && edges < 4) begin
            @(posedge clk);  // first pass is the accepting edge
            if (poke_busy && edges == 1) begin
                start <= 1'b1;  // second request while busy gets dropped
                op    <= mem_pkg::OP_SW;
                addr  <= VICTIM_ADDR;
                wdata <= 32'hdead_beef;
            end else begin
                start <= 1'b0;
            end
            edges++;
            @(negedge clk);
            got = done;
            check_value("busy_o", {31'b0, busy}, 32'h1);  // held up to and with done
        end
        request_count++;
        if (!got) begin
            $display("request %0d: no done_o within 4 cycles of start", request_count);
            error_count++;
            pop_data = exp_data_q.pop_front();
            pop_err  = exp_err_q.pop_front();
            pop_load = is_load_q.pop_front();
        end else begin
            check_value("done_o latency", edges, e_edges);
        end
    endtask

    task automatic misaligned_then_reload(input mem_pkg::mem_op_e rop, input logic [1:0] lane);
        issue_request(rop, {base, lane}, next_random(), 1'b0);
        issue_request(mem_pkg::OP_LW, {base, 2'b00}, 32'h0, 1'b0);  // memory unchanged
    endtask

    // --------------------------------------------------
    // compare process
    // --------------------------------------------------
    always @(negedge clk) begin
        if (!reset && done === 1'b1) begin
            if (exp_err_q.size() == 0) begin
                $display("done_o pulsed with no request outstanding");
                error_count++;
            end else begin
                pop_data = exp_data_q.pop_front();
                pop_err  = exp_err_q.pop_front();
                pop_load = is_load_q.pop_front();
                check_value("err_o", {31'b0, err}, {31'b0, pop_err});
                if (pop_load && !pop_err) check_value("rdata_o", rdata, pop_data);
            end
        end
    end

    // --------------------------------------------------
    // stimulus
    // --------------------------------------------------
    initial begin
        reset = 1'b1;
        start = 1'b0;
        op    = mem_pkg::OP_LW;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_value("busy_o", {31'b0, busy}, 32'h0);
        check_value("done_o", {31'b0, done}, 32'h0);
        check_value("err_o", {31'b0, err}, 32'h0);

        for (i = 0; i < 1024; i++) issue_request(mem_pkg::OP_SW, {i[9:0], 2'b00}, 32'h0, 1'b0);
        for (i = 0; i < 1024; i++) issue_request(mem_pkg::OP_LW, {i[9:0], 2'b00}, 32'h0, 1'b0);

        for (i = 0; i < 32; i++) begin  // random word round trips
            rnd = next_random();
            issue_request(mem_pkg::OP_SW, {rnd[9:0], 2'b00}, next_random(), 1'b0);
            issue_request(mem_pkg::OP_LW, {rnd[9:0], 2'b00}, 32'h0, 1'b0);
        end

        for (i = 0; i < 8; i++) begin  // sub-word stores at every lane
            rnd  = next_random();
            base = rnd[9:0];
            for (j = 0; j < 4; j++) begin
                issue_request(mem_pkg::OP_SB, {base, j[1:0]}, next_random(), 1'b0);
                issue_request(mem_pkg::OP_LW, {base, 2'b00}, 32'h0, 1'b0);
            end
            for (j = 0; j < 4; j += 2) begin
                issue_request(mem_pkg::OP_SH, {base, j[1:0]}, next_random(), 1'b0);
                issue_request(mem_pkg::OP_LW, {base, 2'b00}, 32'h0, 1'b0);
            end
        end

        for (i = 0; i < 2; i++) begin  // sign and zero extension
            rnd  = next_random();
            base = rnd[9:0];
            val  = (i == 0) ? (next_random() | 32'h8080_8080) : (next_random() & 32'h7f7f_7f7f);
            issue_request(mem_pkg::OP_SW, {base, 2'b00}, val, 1'b0);
            for (j = 0; j < 4; j++) begin
                issue_request(mem_pkg::OP_LB, {base, j[1:0]}, 32'h0, 1'b0);
                issue_request(mem_pkg::OP_LBU, {base, j[1:0]}, 32'h0, 1'b0);
            end
            for (j = 0; j < 4; j += 2) begin
                issue_request(mem_pkg::OP_LH, {base, j[1:0]}, 32'h0, 1'b0);
                issue_request(mem_pkg::OP_LHU, {base, j[1:0]}, 32'h0, 1'b0);
            end
        end

        rnd  = next_random();  // misaligned requests
        base = rnd[9:0];
        misaligned_then_reload(mem_pkg::OP_LH, 2'd1);
        misaligned_then_reload(mem_pkg::OP_LH, 2'd3);
        misaligned_then_reload(mem_pkg::OP_LW, 2'd1);
        misaligned_then_reload(mem_pkg::OP_LW, 2'd2);
        misaligned_then_reload(mem_pkg::OP_LW, 2'd3);
        misaligned_then_reload(mem_pkg::OP_SH, 2'd1);
        misaligned_then_reload(mem_pkg::OP_SH, 2'd3);
        misaligned_then_reload(mem_pkg::OP_SW, 2'd1);
        misaligned_then_reload(mem_pkg::OP_SW, 2'd2);
        misaligned_then_reload(mem_pkg::OP_SW, 2'd3);

        // victim word keeps its value after a strobe while busy
        issue_request(mem_pkg::OP_SW, VICTIM_ADDR, 32'h1234_5678, 1'b0);
        issue_request(mem_pkg::OP_SH, 12'h042, next_random(), 1'b1);
        issue_request(mem_pkg::OP_LW, VICTIM_ADDR, 32'h0, 1'b0);

        repeat (4) @(posedge clk);  // room for a stray done_o
        $display("%0d errors in %0d requests", error_count, request_count);
        if (error_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    // --------------------------------------------------
    // watchdog
    // --------------------------------------------------
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired after %0d cycles, run did not complete", WATCHDOG_CYCLES);
        $display("%0d errors in %0d requests", error_count, request_count);
        $display("Finished with errors");
        $finish;
    end

endmodule

//--- sources.f
+incdir+rtl
rtl/mem_pkg.sv
rtl/memory.sv
rtl/load_align.sv
rtl/store_merge.sv
rtl/mem_sequencer.sv
rtl/mem_unit.sv
testbench/tb_mem_unit.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module tb_mem_unit \
    -f sources.f --Mdir obj_dir -o sim_mem_unit
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_mem_unit > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# any failing check leaves the fail line in the log
if grep -q "Finished with errors" "$LOG"; then
    echo "simulation reported errors"
    exit 1
fi

echo "simulation passed"
exit 0
